//--- Makefile
SRCS := $(shell grep -v '^+' filelist.f)

run: obj_dir/Vtb_csr_file
	./obj_dir/Vtb_csr_file | tee sim.log
	grep -q '^TESTS PASSED$$' sim.log

obj_dir/Vtb_csr_file: filelist.f $(SRCS)
	verilator --binary --timing -f filelist.f --top-module tb_csr_file -o Vtb_csr_file

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

//--- csr_access_decode.sv
/* csr operation decode */
`timescale 1ns/1ps
`default_nettype none

module csr_access_decode (
  input  wire logic               csr_access_i,
  input  wire csr_pkg::csr_num_e  csr_addr_i,
  input  wire csr_pkg::csr_op_e   csr_op_i,
  input  wire logic [31:0]        csr_wdata_i,
  input  wire logic               instr_new_id_i,
  input  wire logic [31:0]        rdata_i,       // current value, for set/clear
  input  wire logic               csr_exists_i,
  output csr_pkg::csr_addr_u      addr_o,
  output logic [31:0]             wdata_o,
  output logic                    csr_we_o,
  output logic                    illegal_o
);
  import csr_pkg::*;

  logic wreq;      // op modifies the csr
  logic ro_write;  // write into read-only space

  assign addr_o.num = csr_addr_i;

  // resolve op into the word that gets stored
  always_comb begin
    wreq = 1'b1;
    unique case (csr_op_i)
      CSR_OP_WRITE: wdata_o = csr_wdata_i;
      CSR_OP_SET:   wdata_o = csr_wdata_i | rdata_i;
      CSR_OP_CLEAR: wdata_o = ~csr_wdata_i & rdata_i;
      default: begin  // plain read
        wdata_o = csr_wdata_i;
        wreq    = 1'b0;
      end
    endcase
  end

  // one write per instruction
  assign csr_we_o = wreq & instr_new_id_i;

  // addr[11:10] == 2'b11 marks read-only csrs
  assign ro_write  = csr_access_i & wreq & (csr_addr_i[11:10] == 2'b11);
  assign illegal_o = ~csr_exists_i | ro_write;

endmodule

`default_nettype wire

//--- csr_file_top.sv
/* machine csr file */
`timescale 1ns/1ps
`default_nettype none

module csr_file_top #(
  parameter int unsigned MHPMCounterNum   = 8,
  parameter int unsigned MHPMCounterWidth = 40
) (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  // csr port
  input  wire logic                csr_access_i,
  input  wire csr_pkg::csr_num_e   csr_addr_i,
  input  wire csr_pkg::csr_op_e    csr_op_i,
  input  wire logic [31:0]         csr_wdata_i,
  input  wire logic                instr_new_id_i,
  output logic [31:0]              csr_rdata_o,
  output logic                     illegal_csr_insn_o,
  // interrupts
  input  wire logic                irq_software_i,
  input  wire logic                irq_timer_i,
  input  wire logic                irq_external_i,
  output logic                     irq_pending_o,
  output logic                     csr_msip_o,
  output logic                     csr_mtip_o,
  output logic                     csr_meip_o,
  output logic                     csr_mstatus_mie_o,
  output logic [31:0]              csr_mepc_o,
  output logic [31:0]              csr_mtvec_o,
  // trap controller
  input  wire logic [31:0]         pc_if_i,
  input  wire logic [31:0]         pc_id_i,
  input  wire logic                csr_save_if_i,
  input  wire logic                csr_save_id_i,
  input  wire logic                csr_save_cause_i,
  input  wire csr_pkg::exc_cause_t csr_mcause_i,
  input  wire logic [31:0]         csr_mtval_i,
  input  wire logic                csr_restore_mret_i,
  // events
  input  wire logic                instr_ret_i,
  input  wire logic                instr_ret_compressed_i,
  input  wire logic                imiss_i,
  input  wire logic                pc_set_i,
  input  wire logic                jump_i,
  input  wire logic                branch_i,
  input  wire logic                branch_taken_i,
  input  wire logic                mem_load_i,
  input  wire logic                mem_store_i,
  input  wire logic                lsu_busy_i
);
  import csr_pkg::*;
  import hpm_pkg::*;

  csr_addr_u   addr;
  logic [31:0] wdata, mscratch, mtval, mcountinhibit;
  logic        csr_we, csr_exists;
  mstatus_t    mstatus;
  irq_bits_t   mie, mip;
  exc_cause_t  mcause;
  cnt_word_t   counter_value [NumSlots];

  hpm_ctrl_if hpm_ctrl ();

  csr_access_decode i_decode (
    .csr_access_i, .csr_addr_i, .csr_op_i, .csr_wdata_i, .instr_new_id_i,
    .rdata_i      (csr_rdata_o),
    .csr_exists_i (csr_exists),
    .addr_o       (addr),
    .wdata_o      (wdata),
    .csr_we_o     (csr_we),
    .illegal_o    (illegal_csr_insn_o)
  );

  csr_trap_regs i_trap (
    .clk_i, .rst_ni,
    .addr_i   (addr),
    .wdata_i  (wdata),
    .csr_we_i (csr_we),
    .irq_software_i, .irq_timer_i, .irq_external_i,
    .pc_if_i, .pc_id_i, .csr_save_if_i, .csr_save_id_i, .csr_save_cause_i,
    .csr_mcause_i, .csr_mtval_i, .csr_restore_mret_i,
    .mstatus_o  (mstatus),
    .mie_o      (mie),
    .mip_o      (mip),
    .mscratch_o (mscratch),
    .mepc_o     (csr_mepc_o),
    .mcause_o   (mcause),
    .mtval_o    (mtval),
    .mtvec_o    (csr_mtvec_o),
    .irq_pending_o
  );

  hpm_control #(.MHPMCounterNum(MHPMCounterNum)) i_hpm_ctrl (
    .clk_i, .rst_ni,
    .addr_i   (addr),
    .wdata_i  (wdata),
    .csr_we_i (csr_we),
    .instr_ret_i, .instr_ret_compressed_i, .imiss_i, .pc_set_i, .jump_i,
    .branch_i, .branch_taken_i, .mem_load_i, .mem_store_i, .lsu_busy_i,
    .mcountinhibit_o (mcountinhibit),
    .ctrl            (hpm_ctrl)
  );

  ////////////////////////////////////////////////////////////
  // counter slots
  ////////////////////////////////////////////////////////////

  for (genvar s = 0; s < NumSlots; s++) begin : g_slot
    if (s == SlotCycle || s == SlotInstret ||
        (s >= SlotFirstHpm && s < SlotFirstHpm + MHPMCounterNum)) begin : g_cnt
      hpm_counter #(.Width(s < SlotFirstHpm ? 64 : MHPMCounterWidth)) i_cnt (
        .clk_i, .rst_ni,
        .slot_i  (5'(s)),
        .cnt     (hpm_ctrl),
        .value_o (counter_value[s])
      );
    end else begin : g_none
      assign counter_value[s] = '0;  // reserved or unused slot
    end
  end

  csr_read_mux #(
    .MHPMCounterNum   (MHPMCounterNum),
    .MHPMCounterWidth (MHPMCounterWidth)
  ) i_rmux (
    .csr_access_i,
    .addr_i          (addr),
    .mstatus_i       (mstatus),
    .mie_i           (mie),
    .mip_i           (mip),
    .mscratch_i      (mscratch),
    .mepc_i          (csr_mepc_o),
    .mcause_i        (mcause),
    .mtval_i         (mtval),
    .mtvec_i         (csr_mtvec_o),
    .mcountinhibit_i (mcountinhibit),
    .counter_value_i (counter_value),
    .rdata_o         (csr_rdata_o),
    .csr_exists_o    (csr_exists)
  );

  assign csr_msip_o        = mip.software;
  assign csr_mtip_o        = mip.timer;
  assign csr_meip_o        = mip.external;
  assign csr_mstatus_mie_o = mstatus.mie;

endmodule

`default_nettype wire

//--- csr_pkg.sv
/* machine CSR definitions */
`default_nettype none

package csr_pkg;

  ////////////////////////////////////////////////////////////
  // address map
  ////////////////////////////////////////////////////////////

  typedef enum logic [11:0] {
    CSR_MSTATUS       = 12'h300,
    CSR_MISA          = 12'h301,
    CSR_MIE           = 12'h304,
    CSR_MTVEC         = 12'h305,
    CSR_MCOUNTINHIBIT = 12'h320,
    CSR_MSCRATCH      = 12'h340,
    CSR_MEPC          = 12'h341,
    CSR_MCAUSE        = 12'h342,
    CSR_MTVAL         = 12'h343,
    CSR_MIP           = 12'h344,
    CSR_MCYCLE        = 12'hB00,
    CSR_MINSTRET      = 12'hB02,
    CSR_MCYCLEH       = 12'hB80,
    CSR_MINSTRETH     = 12'hB82
  } csr_num_e;

  typedef enum logic [1:0] {
    CSR_OP_READ  = 2'd0,
    CSR_OP_WRITE = 2'd1,
    CSR_OP_SET   = 2'd2,
    CSR_OP_CLEAR = 2'd3
  } csr_op_e;

  // counter space view: upper 7 bits select the bank, low 5 the slot
  typedef struct packed {
    logic [6:0] base;
    logic [4:0] idx;
  } csr_cnt_addr_t;

  typedef union packed {
    csr_num_e      num;
    csr_cnt_addr_t cnt;
  } csr_addr_u;

  localparam logic [6:0] CntBaseEvent = 7'h19; // mhpmevent, 0x320
  localparam logic [6:0] CntBaseLow   = 7'h58; // mhpmcounter, 0xB00
  localparam logic [6:0] CntBaseHigh  = 7'h5C; // mhpmcounterh, 0xB80

  ////////////////////////////////////////////////////////////
  // field positions and constants
  ////////////////////////////////////////////////////////////

  localparam int unsigned IrqSoftBit     = 3;
  localparam int unsigned IrqTimerBit    = 7;
  localparam int unsigned IrqExtBit      = 11;
  localparam int unsigned MstatusMieBit  = 3;
  localparam int unsigned MstatusMpieBit = 7;
  localparam int unsigned MstatusMppLsb  = 11; // 2-bit field

  localparam logic [1:0]  PrivLvlM  = 2'b11;
  localparam logic [31:0] MisaValue = 32'h4000_0104; // mxl=1, I, C

  typedef struct packed {
    logic software;
    logic timer;
    logic external;
  } irq_bits_t;

  typedef struct packed {
    logic       mie;
    logic       mpie;
    logic [1:0] mpp;
  } mstatus_t;

  typedef struct packed {
    logic       irq;  // interrupt, not exception
    logic [4:0] code;
  } exc_cause_t;

endpackage

`default_nettype wire

//--- csr_read_mux.sv
/* csr read select */
`timescale 1ns/1ps
`default_nettype none

module csr_read_mux #(
  parameter int unsigned MHPMCounterNum   = 8,
  parameter int unsigned MHPMCounterWidth = 40
) (
  input  wire logic                csr_access_i,
  input  wire csr_pkg::csr_addr_u  addr_i,
  input  wire csr_pkg::mstatus_t   mstatus_i,
  input  wire csr_pkg::irq_bits_t  mie_i,
  input  wire csr_pkg::irq_bits_t  mip_i,
  input  wire logic [31:0]         mscratch_i,
  input  wire logic [31:0]         mepc_i,
  input  wire csr_pkg::exc_cause_t mcause_i,
  input  wire logic [31:0]         mtval_i,
  input  wire logic [31:0]         mtvec_i,
  input  wire logic [31:0]         mcountinhibit_i,
  input  wire hpm_pkg::cnt_word_t  counter_value_i [hpm_pkg::NumSlots],
  output logic [31:0]              rdata_o,
  output logic                     csr_exists_o
);
  import csr_pkg::*;
  import hpm_pkg::*;

  localparam cnt_word_t HpmMask = {64{1'b1}} >> (64 - MHPMCounterWidth);

  logic [4:0] idx;
  logic       hpm_slot;  // idx names a real hpm counter
  logic       exists;
  cnt_word_t  cnt_sel;

  assign idx      = addr_i.cnt.idx;
  assign hpm_slot = (idx >= SlotFirstHpm) && (idx < SlotFirstHpm + MHPMCounterNum);
  assign cnt_sel  = counter_value_i[idx] & HpmMask;

  always_comb begin
    rdata_o = '0;
    exists  = 1'b1;
    case (addr_i.num)
      CSR_MSTATUS: begin
        rdata_o[MstatusMieBit]                     = mstatus_i.mie;
        rdata_o[MstatusMpieBit]                    = mstatus_i.mpie;
        rdata_o[MstatusMppLsb+1:MstatusMppLsb]     = mstatus_i.mpp;
      end
      CSR_MISA: rdata_o = MisaValue;
      CSR_MIE: begin
        rdata_o[IrqSoftBit]  = mie_i.software;
        rdata_o[IrqTimerBit] = mie_i.timer;
        rdata_o[IrqExtBit]   = mie_i.external;
      end
      CSR_MIP: begin
        rdata_o[IrqSoftBit]  = mip_i.software;
        rdata_o[IrqTimerBit] = mip_i.timer;
        rdata_o[IrqExtBit]   = mip_i.external;
      end
      CSR_MSCRATCH:      rdata_o = mscratch_i;
      CSR_MEPC:          rdata_o = mepc_i;
      CSR_MCAUSE:        rdata_o = {mcause_i.irq, 26'b0, mcause_i.code};
      CSR_MTVAL:         rdata_o = mtval_i;
      CSR_MTVEC:         rdata_o = mtvec_i;
      CSR_MCOUNTINHIBIT: rdata_o = mcountinhibit_i;
      CSR_MCYCLE:        rdata_o = counter_value_i[SlotCycle][31:0];
      CSR_MCYCLEH:       rdata_o = counter_value_i[SlotCycle][63:32];
      CSR_MINSTRET:      rdata_o = counter_value_i[SlotInstret][31:0];
      CSR_MINSTRETH:     rdata_o = counter_value_i[SlotInstret][63:32];
      default: begin
        // counter banks, slots 0..2 are covered above or reserved
        if (!hpm_slot) begin
          exists = 1'b0;
        end else if (addr_i.cnt.base == CntBaseEvent) begin
          rdata_o = 32'd1 << idx;  // hardwired one-hot selector
        end else if (addr_i.cnt.base == CntBaseLow) begin
          rdata_o = cnt_sel[31:0];
        end else if (addr_i.cnt.base == CntBaseHigh) begin
          rdata_o = cnt_sel[63:32];
        end else begin
          exists = 1'b0;
        end
      end
    endcase
  end

  // only a real access can miss
  assign csr_exists_o = exists | ~csr_access_i;

endmodule

`default_nettype wire

//--- csr_trap_regs.sv
/* machine trap registers */
`timescale 1ns/1ps
`default_nettype none

module csr_trap_regs (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  input  wire csr_pkg::csr_addr_u  addr_i,
  input  wire logic [31:0]         wdata_i,
  input  wire logic                csr_we_i,
  input  wire logic                irq_software_i,
  input  wire logic                irq_timer_i,
  input  wire logic                irq_external_i,
  input  wire logic [31:0]         pc_if_i,
  input  wire logic [31:0]         pc_id_i,
  input  wire logic                csr_save_if_i,
  input  wire logic                csr_save_id_i,
  input  wire logic                csr_save_cause_i,
  input  wire csr_pkg::exc_cause_t csr_mcause_i,
  input  wire logic [31:0]         csr_mtval_i,
  input  wire logic                csr_restore_mret_i,
  output csr_pkg::mstatus_t        mstatus_o,
  output csr_pkg::irq_bits_t       mie_o,
  output csr_pkg::irq_bits_t       mip_o,
  output logic [31:0]              mscratch_o,
  output logic [31:0]              mepc_o,
  output csr_pkg::exc_cause_t      mcause_o,
  output logic [31:0]              mtval_o,
  output logic [31:0]              mtvec_o,
  output logic                     irq_pending_o
);
  import csr_pkg::*;

  mstatus_t    mstatus_q, mstatus_d;
  irq_bits_t   mie_q, mie_d;
  logic [31:0] mscratch_q, mscratch_d;
  logic [31:0] mepc_q, mepc_d;
  exc_cause_t  mcause_q, mcause_d;
  logic [31:0] mtval_q, mtval_d;
  logic [31:0] mtvec_q, mtvec_d;
  logic [31:0] exc_pc;

  // trap controller picks the stage, id unless if alone is flagged
  assign exc_pc = (csr_save_if_i && !csr_save_id_i) ? pc_if_i : pc_id_i;

  ////////////////////////////////////////////////////////////
  // next state
  ////////////////////////////////////////////////////////////

  always_comb begin
    mstatus_d  = mstatus_q;
    mie_d      = mie_q;
    mscratch_d = mscratch_q;
    mepc_d     = mepc_q;
    mcause_d   = mcause_q;
    mtval_d    = mtval_q;
    mtvec_d    = mtvec_q;

    if (csr_we_i) begin
      case (addr_i.num)
        CSR_MSTATUS: begin
          mstatus_d.mie  = wdata_i[MstatusMieBit];
          mstatus_d.mpie = wdata_i[MstatusMpieBit];
          mstatus_d.mpp  = PrivLvlM;  // m-mode only
        end
        CSR_MIE: begin
          mie_d.software = wdata_i[IrqSoftBit];
          mie_d.timer    = wdata_i[IrqTimerBit];
          mie_d.external = wdata_i[IrqExtBit];
        end
        CSR_MSCRATCH: mscratch_d = wdata_i;
        CSR_MEPC:     mepc_d     = {wdata_i[31:1], 1'b0};  // halfword aligned
        CSR_MCAUSE:   mcause_d   = '{irq: wdata_i[31], code: wdata_i[4:0]};
        CSR_MTVAL:    mtval_d    = wdata_i;
        CSR_MTVEC:    mtvec_d    = wdata_i;
        default: ;
      endcase
    end

    // trap entry wins over a software write
    if (csr_save_cause_i) begin
      mepc_d         = exc_pc;
      mcause_d       = csr_mcause_i;
      mtval_d        = csr_mtval_i;
      mstatus_d.mpie = mstatus_q.mie;
      mstatus_d.mie  = 1'b0;  // mask irqs in handler
      mstatus_d.mpp  = PrivLvlM;
    end else if (csr_restore_mret_i) begin
      mstatus_d.mie  = mstatus_q.mpie;
      mstatus_d.mpie = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mstatus_q  <= '{mie: 1'b0, mpie: 1'b0, mpp: PrivLvlM};
      mie_q      <= '0;
      mscratch_q <= '0;
      mepc_q     <= '0;
      mcause_q   <= '0;
      mtval_q    <= '0;
      mtvec_q    <= '1;
    end else begin
      mstatus_q  <= mstatus_d;
      mie_q      <= mie_d;
      mscratch_q <= mscratch_d;
      mepc_q     <= mepc_d;
      mcause_q   <= mcause_d;
      mtval_q    <= mtval_d;
      mtvec_q    <= mtvec_d;
    end
  end

  // pending is live, no flop in the path
  assign mip_o.software = irq_software_i & mie_q.software;
  assign mip_o.timer    = irq_timer_i & mie_q.timer;
  assign mip_o.external = irq_external_i & mie_q.external;
  assign irq_pending_o  = mip_o.software | mip_o.timer | mip_o.external;

  assign mstatus_o  = mstatus_q;
  assign mie_o      = mie_q;
  assign mscratch_o = mscratch_q;
  assign mepc_o     = mepc_q;
  assign mcause_o   = mcause_q;
  assign mtval_o    = mtval_q;
  assign mtvec_o    = mtvec_q;

endmodule

`default_nettype wire

//--- filelist.f
csr_pkg.sv
hpm_pkg.sv
hpm_ctrl_if.sv
hpm_counter.sv
csr_access_decode.sv
csr_trap_regs.sv
hpm_control.sv
csr_read_mux.sv
csr_file_top.sv
tb_csr_file.sv

//--- hpm_control.sv
/* performance monitor control */
`timescale 1ns/1ps
`default_nettype none

module hpm_control #(
  parameter int unsigned MHPMCounterNum = 8
) (
  input  wire logic               clk_i,
  input  wire logic               rst_ni,
  input  wire csr_pkg::csr_addr_u addr_i,
  input  wire logic [31:0]        wdata_i,
  input  wire logic               csr_we_i,
  input  wire logic               instr_ret_i,
  input  wire logic               instr_ret_compressed_i,
  input  wire logic               imiss_i,
  input  wire logic               pc_set_i,
  input  wire logic               jump_i,
  input  wire logic               branch_i,
  input  wire logic               branch_taken_i,
  input  wire logic               mem_load_i,
  input  wire logic               mem_store_i,
  input  wire logic               lsu_busy_i,
  output logic [31:0]             mcountinhibit_o,
  hpm_ctrl_if.ctrl                ctrl
);
  import csr_pkg::*;
  import hpm_pkg::*;

  // absent slots always read as inhibited
  localparam logic [31:0] InhibitForce =
      32'(~((64'd1 << (SlotFirstHpm + MHPMCounterNum)) - 64'd1));

  logic [31:0]         inhibit_q;
  logic [NumSlots-1:0] event_lvl;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      inhibit_q <= '0;
    end else if (csr_we_i && addr_i.num == CSR_MCOUNTINHIBIT) begin
      inhibit_q    <= wdata_i;
      inhibit_q[1] <= 1'b0;  // no time counter here
    end
  end

  assign mcountinhibit_o = inhibit_q | InhibitForce;

  ////////////////////////////////////////////////////////////
  // event routing
  ////////////////////////////////////////////////////////////

  always_comb begin
    event_lvl                  = '0;
    event_lvl[SlotCycle]       = 1'b1;
    event_lvl[SlotInstret]     = instr_ret_i;
    event_lvl[EvLsuWait]       = lsu_busy_i;
    event_lvl[EvFetchWait]     = imiss_i & ~pc_set_i;  // skip redirect cycles
    event_lvl[EvLoad]          = mem_load_i;
    event_lvl[EvStore]         = mem_store_i;
    event_lvl[EvJump]          = jump_i;
    event_lvl[EvBranch]        = branch_i;
    event_lvl[EvBranchTaken]   = branch_taken_i;
    event_lvl[EvRetCompressed] = instr_ret_compressed_i;
  end

  assign ctrl.incr  = event_lvl & ~mcountinhibit_o;
  assign ctrl.wdata = wdata_i;

  // mcycle/minstret share the bank layout, so one decode covers all
  always_comb begin
    ctrl.we_lo = '0;
    ctrl.we_hi = '0;
    if (csr_we_i) begin
      if (addr_i.cnt.base == CntBaseLow) ctrl.we_lo[addr_i.cnt.idx] = 1'b1;
      if (addr_i.cnt.base == CntBaseHigh) ctrl.we_hi[addr_i.cnt.idx] = 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- hpm_counter.sv
/* performance counter */
`timescale 1ns/1ps
`default_nettype none

module hpm_counter #(
  parameter int unsigned Width = 64
) (
  input  wire logic       clk_i,
  input  wire logic       rst_ni,
  input  wire logic [4:0] slot_i,  // fixed per instance
  hpm_ctrl_if.cnt         cnt,
  output hpm_pkg::cnt_word_t value_o
);
  import hpm_pkg::*;

  localparam cnt_word_t Mask = {64{1'b1}} >> (64 - Width);

  cnt_word_t cnt_q, cnt_d;

  always_comb begin
    cnt_d = cnt_q;
    // software write overrides the increment
    if (cnt.we_lo[slot_i]) begin
      cnt_d[31:0] = cnt.wdata;
    end else if (cnt.we_hi[slot_i]) begin
      cnt_d[63:32] = cnt.wdata;
    end else if (cnt.incr[slot_i]) begin
      cnt_d = cnt_q + 64'd1;
    end
    cnt_d = cnt_d & Mask;  // wrap at Width
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) cnt_q <= '0;
    else         cnt_q <= cnt_d;
  end

  assign value_o = cnt_q;

endmodule

`default_nettype wire

//--- hpm_ctrl_if.sv
/* counter control bundle */
`timescale 1ns/1ps
`default_nettype none

interface hpm_ctrl_if;
  import hpm_pkg::*;

  logic [31:0]         wdata;  // resolved csr write word
  logic [NumSlots-1:0] we_lo;  // low half load, per slot
  logic [NumSlots-1:0] we_hi;  // high half load, per slot
  logic [NumSlots-1:0] incr;   // already gated by inhibit

  modport ctrl (
    output wdata,
    output we_lo,
    output we_hi,
    output incr
  );

  modport cnt (
    input wdata,
    input we_lo,
    input we_hi,
    input incr
  );

endinterface

`default_nettype wire

//--- hpm_pkg.sv
/* performance monitor definitions */
`default_nettype none

package hpm_pkg;

  localparam int unsigned NumSlots     = 32;
  localparam int unsigned SlotCycle    = 0;
  localparam int unsigned SlotInstret  = 2;
  localparam int unsigned SlotFirstHpm = 3;

  // hardwired event per hpm slot
  typedef enum logic [4:0] {
    EvLsuWait       = 5'd3,  // data side stalls
    EvFetchWait     = 5'd4,  // instr fetch stalls
    EvLoad          = 5'd5,
    EvStore         = 5'd6,
    EvJump          = 5'd7,
    EvBranch        = 5'd8,
    EvBranchTaken   = 5'd9,
    EvRetCompressed = 5'd10
  } hpm_event_e;

  typedef logic [63:0] cnt_word_t;

endpackage

`default_nettype wire

//--- tb_csr_file.sv
/* csr file testbench */
`timescale 1ns/1ps
`default_nettype none

module tb_csr_file;
  import csr_pkg::*;

  localparam int unsigned CntNum   = 8;
  localparam int unsigned CntWidth = 40;

  logic        clk_i, rst_ni;
  // csr port
  logic        csr_access_i, instr_new_id_i, illegal_csr_insn_o;
  csr_num_e    csr_addr_i;
  csr_op_e     csr_op_i;
  logic [31:0] csr_wdata_i, csr_rdata_o;
  // interrupts, trap controller
  logic        irq_software_i, irq_timer_i, irq_external_i;
  logic        irq_pending_o, csr_msip_o, csr_mtip_o, csr_meip_o, csr_mstatus_mie_o;
  logic [31:0] csr_mepc_o, csr_mtvec_o, pc_if_i, pc_id_i, csr_mtval_i;
  logic        csr_save_if_i, csr_save_id_i, csr_save_cause_i, csr_restore_mret_i;
  exc_cause_t  csr_mcause_i;
  // event levels
  logic        instr_ret_i, instr_ret_compressed_i, imiss_i, pc_set_i, jump_i;
  logic        branch_i, branch_taken_i, mem_load_i, mem_store_i, lsu_busy_i;

  string       test_name;
  int unsigned errors, checks;
  logic [15:0] lfsr_q;

  csr_file_top #(
    .MHPMCounterNum   (CntNum),
    .MHPMCounterWidth (CntWidth)
  ) i_dut (.*);

  always #5 clk_i = ~clk_i;  // 10 ns period

  ////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [15:0] lfsr_step(logic [15:0] s);
    logic [15:0] n;
    n = s >> 1;
    if (s[0]) n = n ^ 16'hB400;  // taps 16,14,13,11
    return n;
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] rand_bits(int unsigned n);
    logic [31:0] r;
    r = '0;
    for (int unsigned i = 0; i < n; i++) begin
      r      = {r[30:0], lfsr_q[0]};
      lfsr_q = lfsr_step(lfsr_q);
    end
    return r;
  endfunction

  function automatic logic [31:0] irq_word(irq_bits_t b);
    logic [31:0] w;
    w     = '0;
    w[3]  = b.software;  // msie / msip
    w[7]  = b.timer;
    w[11] = b.external;
    return w;
  endfunction

  task automatic check_word(string what, logic [31:0] exp, logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[FAIL] %s: %s expected %08h got %08h", test_name, what, exp, act);
    end
  endtask

  task automatic check_bit(string what, logic exp, logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[FAIL] %s: %s expected %b got %b", test_name, what, exp, act);
    end
  endtask

  task automatic check_flag(string what, irq_bits_t exp, irq_bits_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[FAIL] %s: %s expected %03b got %03b", test_name, what, exp, act);
    end
  endtask

  // one csr op, committed only when commit is set
  task automatic csr_cmd(logic [11:0] addr, csr_op_e op, logic [31:0] data, logic commit);
    @(negedge clk_i);
    csr_access_i   = 1'b1;
    csr_addr_i     = csr_num_e'(addr);
    csr_op_i       = op;
    csr_wdata_i    = data;
    instr_new_id_i = commit;
    @(negedge clk_i);
    csr_access_i   = 1'b0;
    csr_op_i       = CSR_OP_READ;
    instr_new_id_i = 1'b0;
  endtask

  task automatic csr_read(logic [11:0] addr, output logic [31:0] data);
    @(negedge clk_i);
    csr_access_i = 1'b1;
    csr_addr_i   = csr_num_e'(addr);
    csr_op_i     = CSR_OP_READ;
    #1;  // combinational read settles
    data = csr_rdata_o;
  endtask

  task automatic read_expect(logic [11:0] addr, logic [31:0] exp, string what);
    logic [31:0] got;
    csr_read(addr, got);
    check_word(what, exp, got);
  endtask

  // random level on one event for 16 cycles
  task automatic pulse_random(input bit on_load, output int unsigned hits);
    logic lvl;
    hits = 0;
    repeat (16) begin
      @(negedge clk_i);
      lvl = 1'(rand_bits(1));
      if (on_load) begin
        mem_load_i = lvl;
      end else begin
        instr_ret_i = lvl;
      end
      hits = hits + 32'(lvl);
    end
    @(negedge clk_i);
    mem_load_i  = 1'b0;
    instr_ret_i = 1'b0;
  endtask

  task automatic probe_illegal(logic [11:0] addr, csr_op_e op, logic exp, string what);
    @(negedge clk_i);
    csr_access_i   = 1'b1;
    csr_addr_i     = csr_num_e'(addr);
    csr_op_i       = op;
    instr_new_id_i = 1'b0;  // flag only, no commit
    #1;
    check_bit(what, exp, illegal_csr_insn_o);
  endtask

  ////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////

  task automatic scratch_access();
    logic [31:0] w1, w2, w3, exp;
    test_name = "scratch_access";
    w1 = rand_bits(32);
    w2 = rand_bits(32);
    w3 = rand_bits(32);
    read_expect(CSR_MTVEC, 32'hFFFF_FFFF, "mtvec reset");
    check_word("mtvec port", 32'hFFFF_FFFF, csr_mtvec_o);
    read_expect(CSR_MSCRATCH, 32'h0, "mscratch reset");
    read_expect(CSR_MISA, 32'h4000_0104, "misa");  // mxl 1, I and C
    csr_cmd(CSR_MSCRATCH, CSR_OP_WRITE, w1, 1'b1);
    read_expect(CSR_MSCRATCH, w1, "mscratch write");
    exp = w1 | w2;
    csr_cmd(CSR_MSCRATCH, CSR_OP_SET, w2, 1'b1);
    read_expect(CSR_MSCRATCH, exp, "mscratch set");
    exp = exp & ~w3;
    csr_cmd(CSR_MSCRATCH, CSR_OP_CLEAR, w3, 1'b1);
    read_expect(CSR_MSCRATCH, exp, "mscratch clear");
    csr_cmd(CSR_MSCRATCH, CSR_OP_SET, ~exp, 1'b0);  // no new instr
    read_expect(CSR_MSCRATCH, exp, "set without instr_new_id");
  endtask

  task automatic irq_masking();
    irq_bits_t en, lvl, exp;
    test_name = "irq_masking";
    for (int unsigned i = 0; i < 4; i++) begin
      en  = 3'(rand_bits(3));
      lvl = 3'(rand_bits(3));
      exp = en & lvl;
      csr_cmd(CSR_MIE, CSR_OP_WRITE, irq_word(en), 1'b1);
      read_expect(CSR_MIE, irq_word(en), "mie");
      @(negedge clk_i);
      {irq_software_i, irq_timer_i, irq_external_i} = lvl;
      read_expect(CSR_MIP, irq_word(exp), "mip");
      check_flag("pending outputs", exp, {csr_msip_o, csr_mtip_o, csr_meip_o});
      check_bit("irq_pending_o", |exp, irq_pending_o);
    end
    @(negedge clk_i);
    {irq_software_i, irq_timer_i, irq_external_i} = 3'b000;
  endtask

  task automatic trap_entry_and_mret();
    logic [31:0] pc, tval;
    exc_cause_t  cause;
    test_name = "trap_entry_and_mret";
    pc    = rand_bits(32);
    tval  = rand_bits(32);
    cause = 6'(rand_bits(6));
    csr_cmd(CSR_MSTATUS, CSR_OP_WRITE, 32'h0000_0008, 1'b1);  // mie only
    check_bit("mie before trap", 1'b1, csr_mstatus_mie_o);
    @(negedge clk_i);
    pc_id_i          = pc;
    pc_if_i          = ~pc;  // must not be picked
    csr_save_id_i    = 1'b1;
    csr_save_cause_i = 1'b1;
    csr_mcause_i     = cause;
    csr_mtval_i      = tval;
    @(negedge clk_i);
    csr_save_id_i    = 1'b0;
    csr_save_cause_i = 1'b0;
    check_word("mepc port", pc, csr_mepc_o);
    check_bit("mie after trap", 1'b0, csr_mstatus_mie_o);
    read_expect(CSR_MCAUSE, {cause.irq, 26'b0, cause.code}, "mcause");
    read_expect(CSR_MTVAL, tval, "mtval");
    read_expect(CSR_MSTATUS, 32'h0000_1880, "mstatus after trap");  // mpie, mpp M
    @(negedge clk_i);
    csr_restore_mret_i = 1'b1;
    @(negedge clk_i);
    csr_restore_mret_i = 1'b0;
    check_bit("mie after mret", 1'b1, csr_mstatus_mie_o);
    read_expect(CSR_MSTATUS, 32'h0000_1888, "mstatus after mret");
  endtask

  task automatic inhibit_and_counting();
    logic [31:0] w;
    int unsigned k;
    test_name = "inhibit_and_counting";
    w = rand_bits(32);
    csr_cmd(CSR_MCOUNTINHIBIT, CSR_OP_WRITE, 32'hFFFF_FFFF, 1'b1);
    read_expect(CSR_MCOUNTINHIBIT, 32'hFFFF_FFFD, "inhibit, bit 1 clear");
    csr_cmd(CSR_MCYCLE, CSR_OP_WRITE, w, 1'b1);
    repeat (5) @(negedge clk_i);
    read_expect(CSR_MCYCLE, w, "mcycle held");
    // minstret on its own
    csr_cmd(CSR_MINSTRET, CSR_OP_WRITE, 32'h0, 1'b1);
    csr_cmd(CSR_MCOUNTINHIBIT, CSR_OP_WRITE, ~32'h4, 1'b1);
    read_expect(CSR_MCOUNTINHIBIT, 32'hFFFF_FFF9, "inhibit, minstret on");
    pulse_random(1'b0, k);
    read_expect(CSR_MINSTRET, k, "minstret count");
    // load event, slot 5
    csr_cmd(CSR_MCOUNTINHIBIT, CSR_OP_WRITE, 32'hFFFF_FFFF, 1'b1);
    csr_cmd(12'hB05, CSR_OP_WRITE, 32'h0, 1'b1);
    csr_cmd(CSR_MCOUNTINHIBIT, CSR_OP_WRITE, ~32'h20, 1'b1);
    pulse_random(1'b1, k);
    read_expect(12'hB05, k, "mhpmcounter5 loads");
    // slots 11..31 have no counter
    csr_cmd(CSR_MCOUNTINHIBIT, CSR_OP_WRITE, 32'h0, 1'b1);
    read_expect(CSR_MCOUNTINHIBIT, 32'hFFFF_F800, "absent slots inhibited");
    csr_cmd(CSR_MCOUNTINHIBIT, CSR_OP_WRITE, 32'hFFFF_FFFF, 1'b1);
  endtask

  task automatic counter_width_mask();
    test_name = "counter_width_mask";
    csr_cmd(12'hB83, CSR_OP_WRITE, 32'hFFFF_FFFF, 1'b1);
    read_expect(12'hB83, (32'd1 << (CntWidth - 32)) - 32'd1, "mhpmcounterh3");
    read_expect(12'hB03, 32'h0, "mhpmcounter3 low half");
  endtask

  task automatic illegal_access();
    test_name = "illegal_access";
    probe_illegal(12'h7C5, CSR_OP_READ, 1'b1, "unknown address");
    probe_illegal(12'hB01, CSR_OP_READ, 1'b1, "mhpmcounter1");
    probe_illegal(12'hB00 + 12'(3 + CntNum), CSR_OP_READ, 1'b1, "counter past last");
    probe_illegal(12'hF11, CSR_OP_WRITE, 1'b1, "write to read-only space");
    probe_illegal(12'hC00, CSR_OP_SET, 1'b1, "set in read-only space");
    probe_illegal(12'hC02, CSR_OP_CLEAR, 1'b1, "clear in read-only space");
    probe_illegal(CSR_MSCRATCH, CSR_OP_READ, 1'b0, "mscratch read");
    probe_illegal(CSR_MSCRATCH, CSR_OP_WRITE, 1'b0, "mscratch write");
    probe_illegal(12'hB00 + 12'(2 + CntNum), CSR_OP_READ, 1'b0, "last counter");
    probe_illegal(12'h323, CSR_OP_READ, 1'b0, "mhpmevent3");
    read_expect(12'h323, 32'h0000_0008, "mhpmevent3 selector");  // one-hot slot 3
    @(negedge clk_i);
    csr_access_i = 1'b0;
  endtask

  initial begin
    clk_i                  = 1'b0;
    rst_ni                 = 1'b0;
    lfsr_q                 = 16'd56542;
    errors                 = 0;
    checks                 = 0;
    test_name              = "reset";
    csr_access_i           = 1'b0;
    csr_addr_i             = CSR_MSTATUS;
    csr_op_i               = CSR_OP_READ;
    csr_wdata_i            = '0;
    instr_new_id_i         = 1'b0;
    irq_software_i         = 1'b0;
    irq_timer_i            = 1'b0;
    irq_external_i         = 1'b0;
    pc_if_i                = '0;
    pc_id_i                = '0;
    csr_save_if_i          = 1'b0;
    csr_save_id_i          = 1'b0;
    csr_save_cause_i       = 1'b0;
    csr_mcause_i           = '0;
    csr_mtval_i            = '0;
    csr_restore_mret_i     = 1'b0;
    instr_ret_i            = 1'b0;
    instr_ret_compressed_i = 1'b0;
    imiss_i                = 1'b0;
    pc_set_i               = 1'b0;
    jump_i                 = 1'b0;
    branch_i               = 1'b0;
    branch_taken_i         = 1'b0;
    mem_load_i             = 1'b0;
    mem_store_i            = 1'b0;
    lsu_busy_i             = 1'b0;
    repeat (8) @(posedge clk_i);  // reset held 8 cycles
    @(negedge clk_i);
    rst_ni = 1'b1;

    scratch_access();
    irq_masking();
    trap_entry_and_mret();
    inhibit_and_counting();
    counter_width_mask();
    illegal_access();

    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
